/* run.sh */
#!/bin/sh
# Build the CSR data block testbench with Verilator and run it
rm -f build.log sim.log
verilator --binary --timing --top-module csr_data_tb -f vlog.f -o csr_data_sim \
    > build.log 2>&1 \
    && ./obj_dir/csr_data_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

/* sim/csr_checker.sv */
// Compares the CSR data block outputs with the testbench model values.
// Samples one time unit before each rising edge while check_en is high.
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_checker (
    input  logic                                      clk,
    input  logic                                      check_en,
    input  logic [31:0]                               exp_ro,
    input  logic [31:0]                               exp_rw,
    input  logic                                      exp_valid,
    input  logic [`NUM_FPU_BLOCKS-1:0][`FRM_BITS-1:0] exp_frm,
    input  logic [31:0]                               read_data_ro,
    input  logic [31:0]                               read_data_rw,
    input  logic                                      read_valid,
    input  logic [`NUM_FPU_BLOCKS-1:0][`FRM_BITS-1:0] fpu_frm,
    output int                                        error_count,
    output int                                        check_count
);

    // Falling edge plus this delay lands just before the next rising edge
    localparam int SAMPLE_DELAY = 9;

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0d ns: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    always begin
        @(negedge clk);
        #(SAMPLE_DELAY);
        if (check_en) begin
            compare("read_data_ro", exp_ro, read_data_ro);
            compare("read_data_rw", exp_rw, read_data_rw);
            compare("read_valid", 32'(exp_valid), 32'(read_valid));
            for (int b = 0; b < `NUM_FPU_BLOCKS; b++) begin
                compare($sformatf("fpu_frm[%0d]", b), 32'(exp_frm[b]), 32'(fpu_frm[b]));
            end
        end
    end

endmodule

/* sim/csr_data_tb.sv */
// Testbench for the CSR data block. Drives LFSR stimulus on the falling edge,
// keeps a per-warp FCSR model and lets csr_checker compare the outputs.
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_data_tb;

    localparam int TB_CORE_ID  = 2;
    localparam int TEST_CYCLES = 300;
    localparam int NUM_TESTS   = 5;
    localparam int CYCLE_LIMIT = 2 * NUM_TESTS * TEST_CYCLES;
    localparam int MASK_BITS   = `NUM_WARPS * `NUM_THREADS;

    localparam logic [11:0] FP_ADDRS [4] = '{csr_addr_pkg::FFLAGS, csr_addr_pkg::FRM,
                                             csr_addr_pkg::FCSR, csr_addr_pkg::FCSR};
    localparam logic [11:0] STUB_ADDRS [9] = '{csr_addr_pkg::SATP, csr_addr_pkg::MSTATUS,
        csr_addr_pkg::MEDELEG, csr_addr_pkg::MIDELEG, csr_addr_pkg::MIE, csr_addr_pkg::MTVEC,
        csr_addr_pkg::MEPC, csr_addr_pkg::PMPCFG0, csr_addr_pkg::PMPADDR0};
    localparam logic [11:0] INFO_ADDRS [16] = '{csr_addr_pkg::MVENDORID, csr_addr_pkg::MARCHID,
        csr_addr_pkg::MIMPID, csr_addr_pkg::MISA, csr_addr_pkg::WARP_ID, csr_addr_pkg::CORE_ID,
        csr_addr_pkg::THREAD_MASK, csr_addr_pkg::WARP_MASK, csr_addr_pkg::NUM_THREADS_ADDR,
        csr_addr_pkg::NUM_WARPS_ADDR, csr_addr_pkg::NUM_CORES_ADDR, csr_addr_pkg::MCYCLE,
        csr_addr_pkg::MCYCLE_H, csr_addr_pkg::MINSTRET, csr_addr_pkg::MINSTRET_H,
        csr_addr_pkg::FCSR};

    string test_names [NUM_TESTS] = '{"flag accrual", "software writes",
                                      "rounding-mode lookup", "info registers",
                                      "address validity"};

    logic clk;
    logic reset;
    csr_types_pkg::fpu_flags_t [`NUM_FPU_BLOCKS-1:0] fpu_flags;
    logic [`NUM_FPU_BLOCKS-1:0][`NW_WIDTH-1:0]       fpu_frm_wid;
    csr_types_pkg::csr_write_t                       csr_write;
    csr_types_pkg::csr_read_req_t                    csr_read;
    logic [`PERF_CTR_BITS-1:0]                       cycles;
    logic [`PERF_CTR_BITS-1:0]                       instret;
    logic [`NUM_WARPS-1:0]                           active_warps;
    logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0]         thread_masks;
    logic [31:0]                                     read_data_ro;
    logic [31:0]                                     read_data_rw;
    logic                                            read_valid;
    logic [`NUM_FPU_BLOCKS-1:0][`FRM_BITS-1:0]       fpu_frm;

    logic                                      check_en;
    logic [31:0]                               exp_ro;
    logic [31:0]                               exp_rw;
    logic                                      exp_valid;
    logic [`NUM_FPU_BLOCKS-1:0][`FRM_BITS-1:0] exp_frm;
    int                                        error_count;
    int                                        check_count;
    int                                        cycle_count = 0;
    logic [31:0]                               lfsr;
    csr_types_pkg::fcsr_t                      model_fcsr [`NUM_WARPS];

    csr_data #(
        .CORE_ID (TB_CORE_ID)
    ) i_csr_data (
        .clk          (clk),
        .reset        (reset),
        .fpu_flags    (fpu_flags),
        .fpu_frm_wid  (fpu_frm_wid),
        .csr_write    (csr_write),
        .csr_read     (csr_read),
        .cycles       (cycles),
        .instret      (instret),
        .active_warps (active_warps),
        .thread_masks (thread_masks),
        .read_data_ro (read_data_ro),
        .read_data_rw (read_data_rw),
        .read_valid   (read_valid),
        .fpu_frm      (fpu_frm)
    );

    csr_checker i_checker (
        .clk          (clk),
        .check_en     (check_en),
        .exp_ro       (exp_ro),
        .exp_rw       (exp_rw),
        .exp_valid    (exp_valid),
        .exp_frm      (exp_frm),
        .read_data_ro (read_data_ro),
        .read_data_rw (read_data_rw),
        .read_valid   (read_valid),
        .fpu_frm      (fpu_frm),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < n; i++) begin
            bit_out = lfsr[0];
            lfsr = lfsr >> 1;
            if (bit_out) begin
                lfsr = lfsr ^ 32'hD000_0001;
            end
            value = {value[62:0], bit_out};
        end
        return value;
    endfunction

    function automatic logic in_user_window(input logic [11:0] addr);
        logic [11:0] low_offset;
        logic [11:0] high_offset;
        low_offset  = addr - `MPM_USER_BASE;
        high_offset = addr - `MPM_USER_H_BASE;
        return (low_offset < 12'd32) || (high_offset < 12'd32);
    endfunction

    task automatic drive_inputs(input int test);
        int idx;
        for (int b = 0; b < `NUM_FPU_BLOCKS; b++) begin
            fpu_frm_wid[b]         = `NW_WIDTH'(rand_bits(`NW_WIDTH));
            fpu_flags[b].enable    = (test <= 2) && (rand_bits(2) != '0);
            fpu_flags[b].wid       = `NW_WIDTH'(rand_bits(`NW_WIDTH));
            fpu_flags[b].fflags    = `FFLAGS_BITS'(rand_bits(`FFLAGS_BITS));
        end
        // Often both blocks report to one warp
        if (rand_bits(1) != '0) begin
            fpu_flags[1].wid = fpu_flags[0].wid;
        end
        idx = int'(rand_bits(2));
        csr_write.enable = (test == 2 || test == 3) && (rand_bits(1) != '0);
        csr_write.wid    = `NW_WIDTH'(rand_bits(`NW_WIDTH));
        csr_write.addr   = FP_ADDRS[(test == 3) ? 1 + idx % 2 : idx];
        csr_write.data   = 32'(rand_bits(32));
        csr_read.enable  = 1'(rand_bits(1));
        csr_read.wid     = `NW_WIDTH'(rand_bits(`NW_WIDTH));
        cycles           = `PERF_CTR_BITS'(rand_bits(`PERF_CTR_BITS));
        instret          = `PERF_CTR_BITS'(rand_bits(`PERF_CTR_BITS));
        active_warps     = `NUM_WARPS'(rand_bits(`NUM_WARPS));
        thread_masks     = MASK_BITS'(rand_bits(MASK_BITS));
        idx = int'(rand_bits(2));
        case (test)
            1: csr_read.addr = FP_ADDRS[2 * int'(rand_bits(1))];
            2: csr_read.addr = FP_ADDRS[idx];
            3: csr_read.addr = csr_addr_pkg::FRM;
            4: csr_read.addr = INFO_ADDRS[int'(rand_bits(4))];
            default: begin
                if (idx == 0) begin
                    csr_read.addr = 12'(rand_bits(12));
                end else if (idx == 1) begin
                    csr_read.addr = STUB_ADDRS[int'(rand_bits(8)) % 9];
                end else begin
                    // Straddle both edges of a user window
                    csr_read.addr = ((idx == 2) ? `MPM_USER_BASE : `MPM_USER_H_BASE)
                                    + 12'(rand_bits(6)) - 12'd16;
                end
            end
        endcase
    endtask

    task automatic compute_expected();
        csr_types_pkg::fcsr_t cur;
        cur       = model_fcsr[csr_read.wid];
        exp_ro    = '0;
        exp_rw    = '0;
        exp_valid = 1'b1;
        case (csr_read.addr)
            csr_addr_pkg::FFLAGS:           exp_rw = 32'(cur.fflags);
            csr_addr_pkg::FRM:              exp_rw = 32'(cur.frm);
            csr_addr_pkg::FCSR:             exp_rw = 32'({cur.frm, cur.fflags});
            csr_addr_pkg::MVENDORID:        exp_ro = `VENDOR_ID;
            csr_addr_pkg::MARCHID:          exp_ro = `ARCH_ID;
            csr_addr_pkg::MIMPID:           exp_ro = `IMPL_ID;
            csr_addr_pkg::MISA:             exp_ro = `MISA_VALUE;
            csr_addr_pkg::WARP_ID:          exp_ro = 32'(csr_read.wid);
            csr_addr_pkg::CORE_ID:          exp_ro = 32'(TB_CORE_ID);
            csr_addr_pkg::THREAD_MASK:      exp_ro = 32'(thread_masks[csr_read.wid]);
            csr_addr_pkg::WARP_MASK:        exp_ro = 32'(active_warps);
            csr_addr_pkg::NUM_THREADS_ADDR: exp_ro = 32'(`NUM_THREADS);
            csr_addr_pkg::NUM_WARPS_ADDR:   exp_ro = 32'(`NUM_WARPS);
            csr_addr_pkg::NUM_CORES_ADDR:   exp_ro = 32'(`NUM_CORES_TOTAL);
            csr_addr_pkg::MCYCLE:           exp_ro = 32'(cycles);
            csr_addr_pkg::MCYCLE_H:         exp_ro = 32'(cycles >> 32);
            csr_addr_pkg::MINSTRET:         exp_ro = 32'(instret);
            csr_addr_pkg::MINSTRET_H:       exp_ro = 32'(instret >> 32);
            csr_addr_pkg::SATP, csr_addr_pkg::MSTATUS, csr_addr_pkg::MEDELEG,
            csr_addr_pkg::MIDELEG, csr_addr_pkg::MIE, csr_addr_pkg::MTVEC,
            csr_addr_pkg::MEPC, csr_addr_pkg::PMPCFG0, csr_addr_pkg::PMPADDR0: exp_ro = '0;
            default:                        exp_valid = in_user_window(csr_read.addr);
        endcase
        for (int b = 0; b < `NUM_FPU_BLOCKS; b++) begin
            exp_frm[b] = model_fcsr[fpu_frm_wid[b]].frm;
        end
    endtask

    // Next state after the coming rising edge
    task automatic update_model();
        logic [`FFLAGS_BITS-1:0] accrued;
        csr_types_pkg::fcsr_t    next;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            accrued = '0;
            for (int b = 0; b < `NUM_FPU_BLOCKS; b++) begin
                if (fpu_flags[b].enable && (fpu_flags[b].wid == `NW_WIDTH'(w))) begin
                    accrued = accrued | fpu_flags[b].fflags;
                end
            end
            next        = model_fcsr[w];
            next.fflags = next.fflags | accrued;
            if (csr_write.enable && (csr_write.wid == `NW_WIDTH'(w))) begin
                case (csr_write.addr)
                    csr_addr_pkg::FFLAGS: next.fflags = csr_write.data[4:0];
                    csr_addr_pkg::FRM:    next.frm = csr_write.data[2:0];
                    csr_addr_pkg::FCSR:   next = csr_write.data[7:0];
                    default: ;
                endcase
            end
            model_fcsr[w] = next;
        end
    endtask

    initial begin
        int errors_before;
        lfsr         = 32'ha28e;
        reset        = 1'b1;
        check_en     = 1'b0;
        fpu_flags    = '0;
        fpu_frm_wid  = '0;
        csr_write    = '0;
        csr_read     = '0;
        cycles       = '0;
        instret      = '0;
        active_warps = '0;
        thread_masks = '0;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            model_fcsr[w] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset    = 1'b0;
        check_en = 1'b1;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            errors_before = error_count;
            repeat (TEST_CYCLES) begin
                drive_inputs(t);
                compute_expected();
                update_model();
                @(negedge clk);
            end
            $display("%s done, %0d errors", test_names[t-1], error_count - errors_before);
        end
        check_en = 1'b0;
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* source/csr_addr_pkg.sv */
// CSR address map of the compute core for the write decoder and read mux.
`include "csr_settings.svh"

package csr_addr_pkg;

    typedef enum logic [`CSR_ADDR_BITS-1:0] {
        // Floating point
        FFLAGS           = 'h001,
        FRM              = 'h002,
        FCSR             = 'h003,
        // Supervisor and machine trap stubs
        SATP             = 'h180,
        MSTATUS          = 'h300,
        MISA             = 'h301,
        MEDELEG          = 'h302,
        MIDELEG          = 'h303,
        MIE              = 'h304,
        MTVEC            = 'h305,
        MEPC             = 'h341,
        PMPCFG0          = 'h3A0,
        PMPADDR0         = 'h3B0,
        // Counters
        MCYCLE           = 'hB00,
        MINSTRET         = 'hB02,
        MCYCLE_H         = 'hB80,
        MINSTRET_H       = 'hB82,
        // GPU thread and warp info
        WARP_ID          = 'hCC1,
        CORE_ID          = 'hCC2,
        WARP_MASK        = 'hCC3,
        THREAD_MASK      = 'hCC4,
        // Machine identity
        MVENDORID        = 'hF11,
        MARCHID          = 'hF12,
        MIMPID           = 'hF13,
        NUM_THREADS_ADDR = 'hFC0,
        NUM_WARPS_ADDR   = 'hFC1,
        NUM_CORES_ADDR   = 'hFC2
    } csr_addr_e;

endpackage

/* source/csr_data.sv */
// Top level of one compute core's CSR data block. Wires the update decoder,
// per-warp FCSR slices and combinational read mux; instantiate once per core.
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_data #(
    parameter int CORE_ID = 0
) (
    input  logic                                             clk,
    input  logic                                             reset,
    input  csr_types_pkg::fpu_flags_t [`NUM_FPU_BLOCKS-1:0]  fpu_flags,
    input  logic [`NUM_FPU_BLOCKS-1:0][`NW_WIDTH-1:0]        fpu_frm_wid,
    input  csr_types_pkg::csr_write_t                        csr_write,
    input  csr_types_pkg::csr_read_req_t                     csr_read,
    input  logic [`PERF_CTR_BITS-1:0]                        cycles,
    input  logic [`PERF_CTR_BITS-1:0]                        instret,
    input  logic [`NUM_WARPS-1:0]                            active_warps,
    input  logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0]          thread_masks,
    output logic [31:0]                                      read_data_ro,
    output logic [31:0]                                      read_data_rw,
    output logic                                             read_valid,
    output logic [`NUM_FPU_BLOCKS-1:0][`FRM_BITS-1:0]        fpu_frm
);

    csr_types_pkg::fcsr_update_t [`NUM_WARPS-1:0] warp_update;
    csr_types_pkg::fcsr_t        [`NUM_WARPS-1:0] fcsr_all;

    csr_update_decode i_update_decode (
        .fpu_flags   (fpu_flags),
        .csr_write   (csr_write),
        .warp_update (warp_update)
    );

    for (genvar w = 0; w < `NUM_WARPS; w++) begin : g_warp
        fcsr_warp i_fcsr_warp (
            .clk    (clk),
            .reset  (reset),
            .update (warp_update[w]),
            .fcsr   (fcsr_all[w])
        );
    end

    csr_read_mux #(
        .CORE_ID (CORE_ID)
    ) i_read_mux (
        .fcsr_all     (fcsr_all),
        .csr_read     (csr_read),
        .fpu_frm_wid  (fpu_frm_wid),
        .cycles       (cycles),
        .instret      (instret),
        .active_warps (active_warps),
        .thread_masks (thread_masks),
        .read_data_ro (read_data_ro),
        .read_data_rw (read_data_rw),
        .read_valid   (read_valid),
        .fpu_frm      (fpu_frm)
    );

endmodule

/* source/csr_read_mux.sv */
// Combinational CSR read port and FPU rounding-mode lookup.
// Read data follows the address directly; read_valid flags unknown addresses.
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_read_mux #(
    parameter int CORE_ID = 0
) (
    input  csr_types_pkg::fcsr_t   [`NUM_WARPS-1:0]                  fcsr_all,
    input  csr_types_pkg::csr_read_req_t                             csr_read,
    input  logic [`NUM_FPU_BLOCKS-1:0][`NW_WIDTH-1:0]                fpu_frm_wid,
    input  logic [`PERF_CTR_BITS-1:0]                                cycles,
    input  logic [`PERF_CTR_BITS-1:0]                                instret,
    input  logic [`NUM_WARPS-1:0]                                    active_warps,
    input  logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0]                  thread_masks,
    output logic [31:0]                                              read_data_ro,
    output logic [31:0]                                              read_data_rw,
    output logic                                                     read_valid,
    output logic [`NUM_FPU_BLOCKS-1:0][`FRM_BITS-1:0]                fpu_frm
);

    csr_types_pkg::fcsr_t read_fcsr;
    logic in_user_window;

    assign read_fcsr = fcsr_all[csr_read.wid];

    assign in_user_window =
        ((csr_read.addr >= `MPM_USER_BASE) && (csr_read.addr < `MPM_USER_BASE + 12'd32)) ||
        ((csr_read.addr >= `MPM_USER_H_BASE) && (csr_read.addr < `MPM_USER_H_BASE + 12'd32));

    always_comb begin
        read_data_ro = '0;
        read_data_rw = '0;
        read_valid   = 1'b1;
        case (csr_read.addr)
            csr_addr_pkg::FFLAGS:           read_data_rw = 32'(read_fcsr.fflags);
            csr_addr_pkg::FRM:              read_data_rw = 32'(read_fcsr.frm);
            csr_addr_pkg::FCSR:             read_data_rw = 32'(read_fcsr);

            csr_addr_pkg::MVENDORID:        read_data_ro = `VENDOR_ID;
            csr_addr_pkg::MARCHID:          read_data_ro = `ARCH_ID;
            csr_addr_pkg::MIMPID:           read_data_ro = `IMPL_ID;
            csr_addr_pkg::MISA:             read_data_ro = `MISA_VALUE;

            csr_addr_pkg::WARP_ID:          read_data_ro = 32'(csr_read.wid);
            csr_addr_pkg::CORE_ID:          read_data_ro = 32'(CORE_ID);
            csr_addr_pkg::THREAD_MASK:      read_data_ro = 32'(thread_masks[csr_read.wid]);
            csr_addr_pkg::WARP_MASK:        read_data_ro = 32'(active_warps);
            csr_addr_pkg::NUM_THREADS_ADDR: read_data_ro = 32'(`NUM_THREADS);
            csr_addr_pkg::NUM_WARPS_ADDR:   read_data_ro = 32'(`NUM_WARPS);
            csr_addr_pkg::NUM_CORES_ADDR:   read_data_ro = 32'(`NUM_CORES_TOTAL);

            csr_addr_pkg::MCYCLE:           read_data_ro = cycles[31:0];
            csr_addr_pkg::MCYCLE_H:         read_data_ro = 32'(cycles[`PERF_CTR_BITS-1:32]);
            csr_addr_pkg::MINSTRET:         read_data_ro = instret[31:0];
            csr_addr_pkg::MINSTRET_H:       read_data_ro = 32'(instret[`PERF_CTR_BITS-1:32]);

            // Trap registers are not implemented and read as zero
            csr_addr_pkg::SATP,
            csr_addr_pkg::MSTATUS,
            csr_addr_pkg::MEDELEG,
            csr_addr_pkg::MIDELEG,
            csr_addr_pkg::MIE,
            csr_addr_pkg::MTVEC,
            csr_addr_pkg::MEPC,
            csr_addr_pkg::PMPCFG0,
            csr_addr_pkg::PMPADDR0:         read_data_ro = '0;

            // Perf windows are valid but have no counters behind them
            default:                        read_valid = in_user_window;
        endcase
    end

    // Rounding mode for each FPU block from the warp it names
    for (genvar b = 0; b < `NUM_FPU_BLOCKS; b++) begin : g_frm
        assign fpu_frm[b] = fcsr_all[fpu_frm_wid[b]].frm;
    end

endmodule

/* source/csr_settings.svh */
// Sizes, widths and identity constants shared by the CSR data block.
// Include wherever a count, width or fixed register value is needed.
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define NUM_WARPS        4
`define NW_WIDTH         2
`define NUM_THREADS      4
`define NUM_FPU_BLOCKS   2
`define NUM_CORES_TOTAL  4

`define FFLAGS_BITS      5
`define FRM_BITS         3
`define CSR_ADDR_BITS    12
`define PERF_CTR_BITS    44

// Machine identity
`define VENDOR_ID        32'h0000_0000
`define ARCH_ID          32'h0000_0002
`define IMPL_ID          32'h0000_0001
// RV32 with A, F, I, M and custom extensions
`define MISA_VALUE       32'h4080_1121

// Two user performance counter windows of 32 entries each
`define MPM_USER_BASE    12'hB03
`define MPM_USER_H_BASE  12'hB83

`endif

/* source/csr_types_pkg.sv */
// Packed structs for FCSR state, FPU flag reports, CSR requests and per-warp updates.
`include "csr_settings.svh"

package csr_types_pkg;

    typedef struct packed {
        logic [`FRM_BITS-1:0]    frm;
        logic [`FFLAGS_BITS-1:0] fflags;
    } fcsr_t;

    typedef struct packed {
        logic                    enable;
        logic [`NW_WIDTH-1:0]    wid;
        logic [`FFLAGS_BITS-1:0] fflags;
    } fpu_flags_t;

    typedef struct packed {
        logic                      enable;
        logic [`NW_WIDTH-1:0]      wid;
        logic [`CSR_ADDR_BITS-1:0] addr;
        logic [31:0]               data;
    } csr_write_t;

    typedef struct packed {
        logic                      enable;
        logic [`NW_WIDTH-1:0]      wid;
        logic [`CSR_ADDR_BITS-1:0] addr;
    } csr_read_req_t;

    // Software write fields take priority over accrue in the slice
    typedef struct packed {
        logic [`FFLAGS_BITS-1:0] accrue;
        logic                    fflags_we;
        logic                    frm_we;
        logic [`FFLAGS_BITS-1:0] fflags;
        logic [`FRM_BITS-1:0]    frm;
    } fcsr_update_t;

endpackage

/* source/csr_update_decode.sv */
// Merges FPU exception flag reports and software CSR writes into one
// FCSR update per warp for the warp slices.
`timescale 1ns/100ps
`include "csr_settings.svh"

module csr_update_decode (
    input  csr_types_pkg::fpu_flags_t   [`NUM_FPU_BLOCKS-1:0] fpu_flags,
    input  csr_types_pkg::csr_write_t                         csr_write,
    output csr_types_pkg::fcsr_update_t [`NUM_WARPS-1:0]      warp_update
);

    logic is_fflags;
    logic is_frm;
    logic is_fcsr;
    logic [`FRM_BITS-1:0] write_frm;

    assign is_fflags = (csr_write.addr == csr_addr_pkg::FFLAGS);
    assign is_frm    = (csr_write.addr == csr_addr_pkg::FRM);
    assign is_fcsr   = (csr_write.addr == csr_addr_pkg::FCSR);

    // FCSR carries frm just above the flags
    assign write_frm = is_fcsr ? csr_write.data[`FFLAGS_BITS +: `FRM_BITS]
                               : csr_write.data[`FRM_BITS-1:0];

    always_comb begin
        for (int w = 0; w < `NUM_WARPS; w++) begin
            warp_update[w].accrue = '0;
            for (int b = 0; b < `NUM_FPU_BLOCKS; b++) begin
                if (fpu_flags[b].enable && (fpu_flags[b].wid == `NW_WIDTH'(w))) begin
                    warp_update[w].accrue = warp_update[w].accrue | fpu_flags[b].fflags;
                end
            end

            warp_update[w].fflags_we = 1'b0;
            warp_update[w].frm_we    = 1'b0;
            if (csr_write.enable && (csr_write.wid == `NW_WIDTH'(w))) begin
                warp_update[w].fflags_we = is_fflags || is_fcsr;
                warp_update[w].frm_we    = is_frm || is_fcsr;
            end

            warp_update[w].fflags = csr_write.data[`FFLAGS_BITS-1:0];
            warp_update[w].frm    = write_frm;
        end
    end

endmodule

/* source/fcsr_warp.sv */
// One warp's floating-point CSR. Flags accrue by OR unless software
// overwrites them; rounding mode changes only on a software write.
`timescale 1ns/100ps

module fcsr_warp (
    input  logic                        clk,
    input  logic                        reset,
    input  csr_types_pkg::fcsr_update_t update,
    output csr_types_pkg::fcsr_t        fcsr
);

    always_ff @(posedge clk) begin
        if (reset) begin
            fcsr <= '0;
        end else begin
            if (update.fflags_we) begin
                fcsr.fflags <= update.fflags;
            end else begin
                fcsr.fflags <= fcsr.fflags | update.accrue;
            end

            if (update.frm_we) begin
                fcsr.frm <= update.frm;
            end
        end
    end

endmodule

/* vlog.f */
+incdir+source
source/csr_addr_pkg.sv
source/csr_types_pkg.sv
source/csr_update_decode.sv
source/fcsr_warp.sv
source/csr_read_mux.sv
source/csr_data.sv
sim/csr_checker.sv
sim/csr_data_tb.sv
